//--- Makefile
VERILATOR ?= verilator
FILELIST  ?= build.f
TB_TOP    ?= tftAdapterTb
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?=

.PHONY: lint build sim clean

lint:
	$(VERILATOR) --lint-only --timing $(VFLAGS) -f $(FILELIST) --top-module $(TB_TOP)

build:
	$(VERILATOR) --binary --timing $(VFLAGS) -f $(FILELIST) --top-module $(TB_TOP) \
		-Mdir $(OBJ_DIR) -o V$(TB_TOP)

sim: build
	./$(OBJ_DIR)/V$(TB_TOP) 2>&1 | tee $(LOG)
	@if grep -q "Test failed" $(LOG) || ! grep -q "Test completed successfully" $(LOG); then \
		echo "FAIL"; exit 1; else echo "PASS"; fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- build.f
rtl/tftPkg.sv
rtl/lcdBusWriter.sv
rtl/lcdArbiter.sv
rtl/cmdSequencer.sv
rtl/pixelStreamer.sv
rtl/tftAdapter.sv
verif/tbClock.sv
verif/tftAdapterTb.sv

//--- rtl/cmdSequencer.sv
`timescale 1ns/1ps

module cmdSequencer #(
    parameter int hActive = tftPkg::defaultHActive,
    parameter int vActive = tftPkg::defaultVActive
) (
    input  logic                          clk,
    input  logic                          rst_n,
    output logic                          seqReq,
    output logic [tftPkg::lcdOpWidth-1:0] seqOp,
    output tftPkg::lcdWord_u              seqWord,
    input  logic                          seqDone,
    output logic                          frameStart,
    input  logic                          frameDone
);
    import tftPkg::*;

    logic [4:0]            step;                            // 0..7 wake-up, 8..27 frame.
    logic                  hold;                            // Gap cycle after each done.
    logic [delayWidth-1:0] delayCnt;                        // Sleep-out settle count.
    logic [4:0]            winOffset;                       // Position in window block.
    logic [2:0]            winPair;                         // Columns 0..3, rows 4..7.
    logic [15:0]           winEnd;                          // Last column or row.
    logic [7:0]            winByte;                         // Data byte of the pair.

    assign winOffset = step - 5'd9;
    assign winPair   = winOffset[3:1];
    assign winEnd    = winPair[2] ? 16'(vActive - 1) : 16'(hActive - 1);
    // Index 0 and 1 carry the start (0), 2 and 3 the end.
    assign winByte   = !winPair[1] ? 8'h00 : (winPair[0] ? winEnd[7:0] : winEnd[15:8]);

    assign seqReq = (step != 5'd3) && (step != 5'd26) && !hold;

    ////////////////////////////////////////////////////////////
    // Operation for each step.
    always_comb begin
        seqOp   = opCmd;
        seqWord = '0;
        if (step >= 5'd9 && step <= 5'd24) begin
            if (winOffset[0]) begin
                seqOp   = opData;
                seqWord = {8'h00, winByte};
            end else begin
                seqWord.cmd.opcode = winPair[2] ? cmdRowSet : cmdColSet;
                seqWord.cmd.index  = {6'd0, winPair[1:0]};
            end
        end else begin
            case (step)
                5'd0: seqOp = opReset;
                5'd1, 5'd8: seqOp = opChipSel;              // CS low.
                5'd2: seqWord.cmd.opcode = cmdSleepOut;
                5'd4: seqWord.cmd.opcode = cmdDisplayOn;
                5'd5: seqWord.cmd.opcode = cmdScanDir;
                5'd6: begin
                    seqOp   = opData;
                    seqWord = scanDirValue;
                end
                5'd7, 5'd27: begin
                    seqOp   = opChipSel;                    // CS high.
                    seqWord = 16'd1;
                end
                5'd25: seqWord.cmd.opcode = cmdMemWrite;
                default: seqWord = '0;                      // No bus use.
            endcase
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            step       <= '0;
            hold       <= 1'b0;
            delayCnt   <= '0;
            frameStart <= 1'b0;
        end else begin
            hold       <= seqDone;
            frameStart <= 1'b0;
            case (step)
                5'd3: begin
                    if (delayCnt == delayWidth'(wakeDelayCycles - 1)) begin
                        delayCnt <= '0;
                        step     <= step + 5'd1;
                    end else begin
                        delayCnt <= delayCnt + 1'b1;
                    end
                end
                5'd25: begin
                    if (seqDone) begin
                        frameStart <= 1'b1;                 // Streamer owns the frame.
                        step       <= 5'd26;
                    end
                end
                5'd26: if (frameDone) step <= 5'd27;
                5'd27: if (seqDone) step <= 5'd8;           // Next frame.
                default: if (seqDone) step <= step + 5'd1;
            endcase
        end
    end

endmodule

//--- rtl/lcdArbiter.sv
`timescale 1ns/1ps

module lcdArbiter (
    input  logic                          clk,
    input  logic                          rst_n,
    input  logic                          seqReq,
    input  logic [tftPkg::lcdOpWidth-1:0] seqOp,
    input  tftPkg::lcdWord_u              seqWord,
    output logic                          seqDone,
    input  logic                          pixReq,
    input  logic [tftPkg::lcdOpWidth-1:0] pixOp,
    input  tftPkg::lcdWord_u              pixWord,
    output logic                          pixDone,
    output logic                          busReq,
    output logic [tftPkg::lcdOpWidth-1:0] busOp,
    output tftPkg::lcdWord_u              busWord,
    input  logic                          busDone
);

    logic busy;                                             // Operation in flight.
    logic ownerPix;                                         // Grant held by the streamer.

    // Grant only between operations, sequencer first.
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            busy     <= 1'b0;
            ownerPix <= 1'b0;
        end else if (!busy) begin
            if (seqReq) begin
                busy     <= 1'b1;
                ownerPix <= 1'b0;
            end else if (pixReq) begin
                busy     <= 1'b1;
                ownerPix <= 1'b1;
            end
        end else if (busDone) begin
            busy <= 1'b0;                                   // Free after writer done.
        end
    end

    assign busReq  = busy && (ownerPix ? pixReq : seqReq);
    assign busOp   = ownerPix ? pixOp : seqOp;
    assign busWord = ownerPix ? pixWord : seqWord;
    assign seqDone = busDone && busy && !ownerPix;          // Owner only.
    assign pixDone = busDone && busy && ownerPix;

endmodule

//--- rtl/lcdBusWriter.sv
`timescale 1ns/1ps

module lcdBusWriter (
    input  logic                          clk,
    input  logic                          rst_n,
    input  logic                          req,
    input  logic [tftPkg::lcdOpWidth-1:0] op,
    input  tftPkg::lcdWord_u              word,
    output logic                          done,
    output logic                          lcdRst,
    output logic                          lcdBacklight,
    output logic                          lcdCs,
    output logic                          lcdRs,
    output logic                          lcdWr,
    output logic                          lcdRd,
    output logic [15:0]                   lcdData
);
    import tftPkg::*;

    logic [1:0]            state;                           // Writer FSM.
    logic [phaseWidth-1:0] phaseCnt;                        // Cycles spent in a phase.
    logic                  accept;                          // New operation taken.

    // Done still high means the master has not dropped req yet.
    assign accept = (state == wrIdle) && req && !done;
    assign lcdRd  = 1'b1;                                   // Read path unused.

    always_ff @(posedge clk) begin
        if (accept && (op == opData || op == opCmd)) begin
            lcdData <= word;                                // Stable through the strobe.
        end
    end

    ////////////////////////////////////////////////////////////
    // Reset pulse, CS level and write strobe.
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state        <= wrIdle;
            phaseCnt     <= '0;
            done         <= 1'b0;
            lcdRst       <= 1'b0;                           // Pulse still to come.
            lcdBacklight <= 1'b0;
            lcdCs        <= 1'b1;
            lcdRs        <= 1'b0;
            lcdWr        <= 1'b1;
        end else begin
            done <= 1'b0;                                   // Single-cycle pulse.
            case (state)
                wrIdle: begin
                    if (accept) begin
                        phaseCnt <= '0;
                        case (op)
                            opReset: begin
                                lcdRst <= 1'b0;
                                state  <= wrRstLow;
                            end
                            opChipSel: begin
                                lcdCs <= word[0];           // Level from bit 0.
                                done  <= 1'b1;
                            end
                            default: begin
                                lcdRs <= (op == opData);    // Low for commands.
                                lcdWr <= 1'b0;
                                state <= wrStrobeLow;
                            end
                        endcase
                    end
                end
                wrRstLow: begin
                    if (phaseCnt == phaseWidth'(rstLowCycles - 1)) begin
                        lcdRst       <= 1'b1;               // Release panel.
                        lcdBacklight <= 1'b1;
                        done         <= 1'b1;
                        state        <= wrIdle;
                    end else begin
                        phaseCnt <= phaseCnt + 1'b1;
                    end
                end
                wrStrobeLow: begin
                    if (phaseCnt == phaseWidth'(wrLowCycles - 1)) begin
                        lcdWr    <= 1'b1;                   // Panel samples here.
                        phaseCnt <= '0;
                        state    <= wrStrobeHigh;
                    end else begin
                        phaseCnt <= phaseCnt + 1'b1;
                    end
                end
                default: begin
                    if (phaseCnt == phaseWidth'(wrHighCycles - 1)) begin
                        done  <= 1'b1;
                        state <= wrIdle;
                    end else begin
                        phaseCnt <= phaseCnt + 1'b1;
                    end
                end
            endcase
        end
    end

endmodule

//--- rtl/pixelStreamer.sv
`timescale 1ns/1ps

module pixelStreamer #(
    parameter int hActive = tftPkg::defaultHActive,
    parameter int vActive = tftPkg::defaultVActive
) (
    input  logic                              clk,
    input  logic                              rst_n,
    input  logic                              frameStart,
    output logic                              frameDone,
    output logic                              pixReq,
    output logic [tftPkg::lcdOpWidth-1:0]     pixOp,
    output tftPkg::lcdWord_u                  pixWord,
    input  logic                              pixDone,
    output logic [tftPkg::sdramAddrWidth-1:0] sdramRdAddr,
    output logic                              sdramRdReq,
    input  logic                              sdramRdDone,
    input  logic [15:0]                       sdramData0,
    input  logic [15:0]                       sdramData1,
    input  logic [15:0]                       sdramData2,
    input  logic [15:0]                       sdramData3
);
    import tftPkg::*;

    logic                          writing;                 // Draining the buffer.
    logic                          hold;                    // Gap cycle after each done.
    logic [$clog2(burstWords)-1:0] wordIdx;                 // Next buffered word.
    logic [15:0]                   pixBuf [burstWords];     // One SDRAM group.
    logic [sdramAddrWidth-1:0]     lastAddr;                // Start of the final group.

    assign lastAddr = sdramAddrWidth'(hActive * vActive - burstWords);
    assign pixReq   = writing && !hold;
    assign pixOp    = opData;
    assign pixWord  = pixBuf[wordIdx];

    always_ff @(posedge clk) begin
        if (sdramRdReq && sdramRdDone) begin
            pixBuf[0] <= sdramData0;                        // Word at the address.
            pixBuf[1] <= sdramData1;
            pixBuf[2] <= sdramData2;
            pixBuf[3] <= sdramData3;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            sdramRdReq  <= 1'b0;
            sdramRdAddr <= '0;
            writing     <= 1'b0;
            hold        <= 1'b0;
            wordIdx     <= '0;
            frameDone   <= 1'b0;
        end else begin
            hold      <= pixDone;
            frameDone <= 1'b0;
            if (frameStart && !sdramRdReq && !writing) begin
                sdramRdReq <= 1'b1;                         // First group.
            end
            if (sdramRdReq && sdramRdDone) begin
                sdramRdReq <= 1'b0;
                writing    <= 1'b1;
                wordIdx    <= '0;
            end
            if (pixDone) begin
                if (wordIdx == $bits(wordIdx)'(burstWords - 1)) begin
                    writing <= 1'b0;
                    if (sdramRdAddr == lastAddr) begin
                        sdramRdAddr <= '0;                  // Wrap for next frame.
                        frameDone   <= 1'b1;
                    end else begin
                        sdramRdAddr <= sdramRdAddr + sdramAddrWidth'(burstWords);
                        sdramRdReq  <= 1'b1;
                    end
                end else begin
                    wordIdx <= wordIdx + 1'b1;
                end
            end
        end
    end

endmodule

//--- rtl/tftAdapter.sv
`timescale 1ns/1ps

module tftAdapter #(
    parameter int hActive = tftPkg::defaultHActive,
    parameter int vActive = tftPkg::defaultVActive
) (
    input  logic                              clk,
    input  logic                              rst_n,
    output logic [tftPkg::sdramAddrWidth-1:0] sdramRdAddr,
    output logic                              sdramRdReq,
    input  logic                              sdramRdDone,
    input  logic [15:0]                       sdramData0,
    input  logic [15:0]                       sdramData1,
    input  logic [15:0]                       sdramData2,
    input  logic [15:0]                       sdramData3,
    output logic                              lcdRst,
    output logic                              lcdBacklight,
    output logic                              lcdCs,
    output logic                              lcdRs,
    output logic                              lcdWr,
    output logic                              lcdRd,
    output logic [15:0]                       lcdData
);
    import tftPkg::*;

    logic                  seqReq, seqDone, pixReq, pixDone;
    logic                  busReq, busDone, frameStart, frameDone;
    logic [lcdOpWidth-1:0] seqOp, pixOp, busOp;
    lcdWord_u              seqWord, pixWord, busWord;

    ////////////////////////////////////////////////////////////
    // Two engines sharing one panel bus.
    cmdSequencer #(.hActive(hActive), .vActive(vActive)) uSeq (
        .clk(clk), .rst_n(rst_n),
        .seqReq(seqReq), .seqOp(seqOp), .seqWord(seqWord), .seqDone(seqDone),
        .frameStart(frameStart), .frameDone(frameDone)
    );

    pixelStreamer #(.hActive(hActive), .vActive(vActive)) uPix (
        .clk(clk), .rst_n(rst_n),
        .frameStart(frameStart), .frameDone(frameDone),
        .pixReq(pixReq), .pixOp(pixOp), .pixWord(pixWord), .pixDone(pixDone),
        .sdramRdAddr(sdramRdAddr), .sdramRdReq(sdramRdReq), .sdramRdDone(sdramRdDone),
        .sdramData0(sdramData0), .sdramData1(sdramData1),
        .sdramData2(sdramData2), .sdramData3(sdramData3)
    );

    lcdArbiter uArb (
        .clk(clk), .rst_n(rst_n),
        .seqReq(seqReq), .seqOp(seqOp), .seqWord(seqWord), .seqDone(seqDone),
        .pixReq(pixReq), .pixOp(pixOp), .pixWord(pixWord), .pixDone(pixDone),
        .busReq(busReq), .busOp(busOp), .busWord(busWord), .busDone(busDone)
    );

    lcdBusWriter uWriter (
        .clk(clk), .rst_n(rst_n),
        .req(busReq), .op(busOp), .word(busWord), .done(busDone),
        .lcdRst(lcdRst), .lcdBacklight(lcdBacklight), .lcdCs(lcdCs),
        .lcdRs(lcdRs), .lcdWr(lcdWr), .lcdRd(lcdRd), .lcdData(lcdData)
    );

endmodule

//--- rtl/tftPkg.sv
package tftPkg;

    ////////////////////////////////////////////////////////////
    // Bus writer operations and states.
    localparam int lcdOpWidth = 2;                          // Operation code width.

    localparam logic [lcdOpWidth-1:0] opReset   = 2'd0;     // Reset pulse, then backlight.
    localparam logic [lcdOpWidth-1:0] opChipSel = 2'd1;     // CS level from word bit 0.
    localparam logic [lcdOpWidth-1:0] opData    = 2'd2;     // Write with RS high.
    localparam logic [lcdOpWidth-1:0] opCmd     = 2'd3;     // Write with RS low.

    localparam logic [1:0] wrIdle       = 2'd0;             // Waiting for a request.
    localparam logic [1:0] wrRstLow     = 2'd1;             // Holding LCD_RST low.
    localparam logic [1:0] wrStrobeLow  = 2'd2;             // WR low phase.
    localparam logic [1:0] wrStrobeHigh = 2'd3;             // WR high phase.

    ////////////////////////////////////////////////////////////
    // Panel command set.
    localparam logic [7:0] cmdSleepOut  = 8'h11;            // Leave sleep mode.
    localparam logic [7:0] cmdDisplayOn = 8'h29;            // Enable output.
    localparam logic [7:0] cmdScanDir   = 8'h36;            // Memory access control.
    localparam logic [7:0] cmdColSet    = 8'h2A;            // CASET.
    localparam logic [7:0] cmdRowSet    = 8'h2B;            // RASET.
    localparam logic [7:0] cmdMemWrite  = 8'h2C;            // RAMWR.

    localparam logic [15:0] scanDirValue = 16'h0000;        // Default scan, RGB order.

    ////////////////////////////////////////////////////////////
    // Timing, widths and frame size.
    localparam int wrLowCycles     = 2;                     // WR low length.
    localparam int wrHighCycles    = 2;                     // WR high length.
    localparam int rstLowCycles    = 16;                    // Reset pulse length.
    localparam int wakeDelayCycles = 500;                   // Settle after sleep-out.
    localparam int phaseWidth      = $clog2(rstLowCycles + 1);
    localparam int delayWidth      = $clog2(wakeDelayCycles + 1);

    localparam int sdramAddrWidth = 24;                     // Bank, row and column.
    localparam int burstWords     = 4;                      // Words per SDRAM read.
    localparam int defaultHActive = 480;                    // Columns.
    localparam int defaultVActive = 800;                    // Rows.

    // One bus word, seen either as a command or as a pixel.
    typedef struct packed {
        logic [7:0] opcode;                                 // Command code.
        logic [7:0] index;                                  // Parameter index.
    } lcdCmd_t;

    typedef struct packed {
        logic [4:0] red;
        logic [5:0] green;
        logic [4:0] blue;
    } lcdPixel_t;                                           // RGB565.

    typedef union packed {
        lcdCmd_t   cmd;
        lcdPixel_t pixel;
    } lcdWord_u;

endpackage

//--- verif/tbClock.sv
`timescale 1ns/1ps

module tbClock (
    output logic clk,
    output logic rst_n
);

    initial begin
        clk   = 1'b0;
        rst_n = 1'b0;                                       // Reset from time zero.
        repeat (2) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;                                       // Release away from posedge.
    end

    always #10 clk = ~clk;                                  // 20 ns period.

endmodule

//--- verif/tftAdapterTb.sv
`timescale 1ns/1ps

module tftAdapterTb;
    import tftPkg::*;

    localparam int hActive      = 8;                        // Small frame.
    localparam int vActive      = 4;
    localparam int frameWords   = hActive * vActive;
    localparam int eventTimeout = 1000;                     // Cycles per panel event.
    localparam logic [1:0] evCsLow  = 2'd0;                 // Captured event kinds.
    localparam logic [1:0] evCsHigh = 2'd1;
    localparam logic [1:0] evCmd    = 2'd2;
    localparam logic [1:0] evData   = 2'd3;

    logic clk, rst_n, sdramRdReq, sdramRdDone;
    logic [sdramAddrWidth-1:0] sdramRdAddr;
    logic [15:0] sdramData0, sdramData1, sdramData2, sdramData3;
    logic lcdRst, lcdBacklight, lcdCs, lcdRs, lcdWr, lcdRd;
    logic [15:0] lcdData;

    logic [1:0]                capKind [$];             // Panel monitor log.
    lcdWord_u                  capWord [$];
    logic [1:0]                expKind [$];             // Expected-write table.
    lcdWord_u                  expWord [$];
    logic [31:0]               rngState = 32'd4301;     // Read delay generator.
    logic [2:0]                delayLeft;
    logic                      readPending = 1'b0;
    logic [sdramAddrWidth-1:0] expAddr = '0;            // Next group address.

    tbClock clockGen (.clk(clk), .rst_n(rst_n));

    tftAdapter #(.hActive(hActive), .vActive(vActive)) UUT (
        .clk(clk), .rst_n(rst_n),
        .sdramRdAddr(sdramRdAddr), .sdramRdReq(sdramRdReq), .sdramRdDone(sdramRdDone),
        .sdramData0(sdramData0), .sdramData1(sdramData1),
        .sdramData2(sdramData2), .sdramData3(sdramData3),
        .lcdRst(lcdRst), .lcdBacklight(lcdBacklight), .lcdCs(lcdCs),
        .lcdRs(lcdRs), .lcdWr(lcdWr), .lcdRd(lcdRd), .lcdData(lcdData)
    );

    ////////////////////////////////////////////////////////////
    // Helpers and compare tasks.
    function automatic logic [31:0] xorshift(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    function automatic logic [15:0] modelWord(input int addr);
        logic [31:0] r;
        r = xorshift(32'(addr) + 32'd4301);                 // SDRAM contents.
        return r[15:0];
    endfunction

    function automatic string kindName(input logic [1:0] kind);
        case (kind)
            evCsLow:  return "CS low";
            evCsHigh: return "CS high";
            evCmd:    return "command";
            default:  return "data";
        endcase
    endfunction

    task automatic failRun(input string msg);
        $display("%s", msg);
        $display("Test failed");
        $fatal(1, "stopping at first error");
    endtask

    task automatic checkPin(input string name, input logic got, input logic exp);
        if (got !== exp)
            failRun($sformatf("Mismatch at %0t: %s got %b expected %b", $time, name, got, exp));
    endtask

    task automatic checkCmd(input lcdWord_u got, input lcdWord_u exp);
        if (got.cmd !== exp.cmd)
            failRun($sformatf("Mismatch at %0t: lcdData cmd got %h/%h expected %h/%h", $time,
                got.cmd.opcode, got.cmd.index, exp.cmd.opcode, exp.cmd.index));
    endtask

    task automatic checkData(input lcdWord_u got, input lcdWord_u exp);
        if (got !== exp)
            failRun($sformatf("Mismatch at %0t: lcdData got %h (r%0d g%0d b%0d) expected %h",
                $time, got, got.pixel.red, got.pixel.green, got.pixel.blue, exp));
    endtask

    task automatic checkAddr(input logic [sdramAddrWidth-1:0] got,
                             input logic [sdramAddrWidth-1:0] exp);
        if (got !== exp)
            failRun($sformatf("Mismatch at %0t: sdramRdAddr got %h expected %h", $time, got, exp));
    endtask

    task automatic addEntry(input logic [1:0] kind, input lcdWord_u word);
        expKind.push_back(kind);
        expWord.push_back(word);
    endtask

    task automatic addCmd(input logic [7:0] opcode, input logic [7:0] index);
        lcdWord_u w;
        w.cmd.opcode = opcode;
        w.cmd.index  = index;
        addEntry(evCmd, w);
    endtask

    // Window bytes: start high, start low, end high, end low.
    task automatic addWindow(input logic [7:0] opcode, input logic [15:0] endVal);
        for (int idx = 0; idx < 4; idx++) begin
            addCmd(opcode, 8'(idx));
            addEntry(evData, (idx < 2) ? 16'h0 : ((idx == 2) ? {8'h0, endVal[15:8]}
                                                             : {8'h0, endVal[7:0]}));
        end
    endtask

    task automatic buildTable();
        addEntry(evCsLow, '0);                              // Wake-up block.
        addCmd(cmdSleepOut, 8'd0);
        addCmd(cmdDisplayOn, 8'd0);
        addCmd(cmdScanDir, 8'd0);
        addEntry(evData, scanDirValue);
        addEntry(evCsHigh, '0);
        for (int f = 0; f < 3; f++) begin
            addEntry(evCsLow, '0);
            addWindow(cmdColSet, 16'(hActive - 1));
            addWindow(cmdRowSet, 16'(vActive - 1));
            addCmd(cmdMemWrite, 8'd0);
            for (int a = 0; a < frameWords; a++) begin
                addEntry(evData, modelWord(a));             // Address restarts each frame.
            end
            addEntry(evCsHigh, '0);
        end
    endtask

    ////////////////////////////////////////////////////////////
    // SDRAM model and panel monitor.
    always @(negedge clk) begin
        if (rst_n === 1'b1) begin
            if (sdramRdDone) begin
                checkPin("sdramRdReq", sdramRdReq, 1'b0);  // Dropped after done.
                sdramRdDone = 1'b0;
                readPending = 1'b0;
            end else if (sdramRdReq) begin
                checkAddr(sdramRdAddr, expAddr);            // Held and in sequence.
                checkPin("lcdWr", lcdWr, 1'b1);             // No strobe while stalled.
                if (!readPending) begin
                    readPending = 1'b1;
                    rngState    = xorshift(rngState);
                    delayLeft   = rngState[2:0];            // 0 to 7 cycles.
                end
                if (delayLeft == 3'd0) begin
                    sdramData0  = modelWord(int'(expAddr));
                    sdramData1  = modelWord(int'(expAddr) + 1);
                    sdramData2  = modelWord(int'(expAddr) + 2);
                    sdramData3  = modelWord(int'(expAddr) + 3);
                    sdramRdDone = 1'b1;
                    expAddr     = (int'(expAddr) + 4 == frameWords) ? '0 : expAddr + 24'd4;
                end else begin
                    delayLeft = delayLeft - 3'd1;
                end
            end else if (readPending) begin
                failRun("sdramRdReq dropped before sdramRdDone");
            end
        end
    end

    always @(posedge lcdWr) begin
        if (rst_n === 1'b1) begin
            if (lcdCs !== 1'b0) failRun("panel write strobe while CS was high");
            capKind.push_back(lcdRs ? evData : evCmd);      // RS high marks data.
            capWord.push_back(lcdData);
        end
    end

    always @(posedge lcdCs or negedge lcdCs) begin
        if (rst_n === 1'b1) begin
            capKind.push_back(lcdCs ? evCsHigh : evCsLow);
            capWord.push_back('0);
        end
    end

    ////////////////////////////////////////////////////////////
    // Reset checks, then the table walk.
    initial begin
        int cycles;
        logic [1:0] gotKind;
        lcdWord_u   gotWord;
        sdramRdDone = 1'b0;
        sdramData0  = '0;
        sdramData1  = '0;
        sdramData2  = '0;
        sdramData3  = '0;
        buildTable();
        cycles = 0;
        while (rst_n !== 1'b1 && cycles < 10) begin
            @(posedge clk);
            cycles++;
        end
        if (rst_n !== 1'b1) failRun("reset was never released");
        @(negedge clk);
        checkPin("lcdRst", lcdRst, 1'b0);                   // Pulse not yet issued.
        checkPin("lcdBacklight", lcdBacklight, 1'b0);
        checkPin("lcdCs", lcdCs, 1'b1);
        checkPin("lcdWr", lcdWr, 1'b1);
        checkPin("lcdRd", lcdRd, 1'b1);
        checkPin("sdramRdReq", sdramRdReq, 1'b0);
        cycles = 0;
        while (lcdRst !== 1'b1 && cycles < 100) begin
            @(negedge clk);
            cycles++;
        end
        if (lcdRst !== 1'b1) failRun("panel reset pulse never ended");
        checkPin("lcdBacklight", lcdBacklight, 1'b1);
        if (capKind.size() != 0) failRun("panel bus activity before the reset pulse ended");
        for (int i = 0; i < expKind.size(); i++) begin
            cycles = 0;
            while (capKind.size() == 0 && cycles < eventTimeout) begin
                @(negedge clk);
                cycles++;
            end
            if (capKind.size() == 0) failRun($sformatf("timeout waiting for panel event %0d", i));
            gotKind = capKind.pop_front();
            gotWord = capWord.pop_front();
            if (gotKind !== expKind[i])
                failRun($sformatf("Mismatch at %0t: panel event %0d got %s expected %s", $time,
                    i, kindName(gotKind), kindName(expKind[i])));
            else if (gotKind == evCmd)
                checkCmd(gotWord, expWord[i]);
            else if (gotKind == evData)
                checkData(gotWord, expWord[i]);
        end
        $display("Test completed successfully");
        $finish;
    end

endmodule
